// ==== hw/exec_defines.svh ====
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Number of instructions issued to the execute slice per cycle.
// Lane 0 always holds the oldest instruction of the group
`define NUM_LANES 2

// Data path width of the ALUs and the write ports
`define XLEN 32

`endif

// ==== hw/exec_pkg.sv ====
`include "exec_defines.svh"

package exec_pkg;

    // ALU operations as encoded by decode
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SLL  = 4'd10,
        ALU_SRL  = 4'd11,
        ALU_SRA  = 4'd12,
        ALU_LUI  = 4'd13
    } alu_op_e;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } inst_i_t;

    // The same instruction word seen as R-type or as I-type
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_word_u;

    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        inst_word_u       inst;
        logic [`XLEN-1:0] rs_value;
        logic [`XLEN-1:0] rt_value;
        alu_op_e          aluop;
        logic             alu_selb;
        logic             reg_wen;
        logic [4:0]       reg_waddr;
    } issue_lane_t;

    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        logic [`XLEN-1:0] result;
        logic             reg_wen;
        logic [4:0]       reg_waddr;
        logic             overflow;
    } exec_result_t;

    typedef struct packed {
        logic             wen;
        logic [4:0]       waddr;
        logic [`XLEN-1:0] wdata;
    } wb_port_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] epc;
    } except_t;

endpackage

// ==== hw/id_ex_reg.sv ====
`include "exec_defines.svh"

module id_ex_reg
    import exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`NUM_LANES-1:0] ena,
    input  logic [`NUM_LANES-1:0] clear,
    input  issue_lane_t           issue_in [`NUM_LANES],
    output issue_lane_t           issue_q  [`NUM_LANES]
);

    // Per-lane decisions for the coming edge
    logic [`NUM_LANES-1:0] lane_flush;
    logic [`NUM_LANES-1:0] lane_load;

    // Clear takes priority over enable
    assign lane_flush = clear | {`NUM_LANES{reset}};
    assign lane_load  = ena & ~lane_flush;

    generate
        for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
            always_ff @(posedge clk) begin
                if (lane_flush[g]) begin
                    issue_q[g] <= '0;
                end else if (lane_load[g]) begin
                    issue_q[g] <= issue_in[g];
                end else begin
                    // A stalled lane keeps its fields but becomes a bubble,
                    // so the held instruction cannot retire a second time
                    issue_q[g].valid <= 1'b0;
                end
            end
        end
    endgenerate

endmodule

// ==== hw/alu_lane.sv ====
`include "exec_defines.svh"

module alu_lane
    import exec_pkg::*;
(
    input  issue_lane_t  lane,
    output exec_result_t result
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] imm_ext;
    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] diff;
    logic [`XLEN-1:0] alu_out;
    logic [4:0]       shamt;
    logic [15:0]      imm;
    logic             zero_ext;
    logic             add_ovf;
    logic             sub_ovf;

    // Both views of the same word are decoded here
    assign imm   = lane.inst.i.imm;
    assign shamt = lane.inst.r.shamt;

    // Logical immediates (andi, ori, xori) are zero extended
    assign zero_ext = (lane.aluop == ALU_AND) || (lane.aluop == ALU_OR) ||
                      (lane.aluop == ALU_XOR) || (lane.aluop == ALU_NOR);

    assign imm_ext = zero_ext ? {{(`XLEN-16){1'b0}}, imm}
                              : {{(`XLEN-16){imm[15]}}, imm};

    assign op_a = lane.rs_value;
    assign op_b = lane.alu_selb ? imm_ext : lane.rt_value;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // Signed overflow: operands agree in sign but the result does not
    assign add_ovf = (op_a[`XLEN-1] == op_b[`XLEN-1]) &&
                     (sum[`XLEN-1] != op_a[`XLEN-1]);
    assign sub_ovf = (op_a[`XLEN-1] != op_b[`XLEN-1]) &&
                     (diff[`XLEN-1] != op_a[`XLEN-1]);

    always_comb begin
        case (lane.aluop)
            ALU_ADD, ALU_ADDU: alu_out = sum;
            ALU_SUB, ALU_SUBU: alu_out = diff;
            ALU_AND:           alu_out = op_a & op_b;
            ALU_OR:            alu_out = op_a | op_b;
            ALU_XOR:           alu_out = op_a ^ op_b;
            ALU_NOR:           alu_out = ~(op_a | op_b);
            ALU_SLT: begin
                alu_out = {{(`XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            ALU_SLTU: begin
                alu_out = {{(`XLEN-1){1'b0}}, (op_a < op_b)};
            end
            // Shifts act on operand B, the amount comes from shamt
            ALU_SLL:           alu_out = op_b << shamt;
            ALU_SRL:           alu_out = op_b >> shamt;
            ALU_SRA:           alu_out = $signed(op_b) >>> shamt;
            ALU_LUI:           alu_out = `XLEN'(imm) << 16;
            default:           alu_out = '0;
        endcase
    end

    always_comb begin
        result.valid     = lane.valid;
        result.pc        = lane.pc;
        result.result    = alu_out;
        result.reg_wen   = lane.reg_wen;
        result.reg_waddr = lane.reg_waddr;
        // Only the trapping forms raise overflow; addu and subu wrap silently
        result.overflow  = ((lane.aluop == ALU_ADD) && add_ovf) ||
                           ((lane.aluop == ALU_SUB) && sub_ovf);
    end

endmodule

// ==== hw/retire_stage.sv ====
`include "exec_defines.svh"

module retire_stage
    import exec_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  exec_result_t results [`NUM_LANES],
    output wb_port_t     wb      [`NUM_LANES],
    output except_t      except_out
);

    logic [`NUM_LANES-1:0] lane_writes;
    wb_port_t              wb_next [`NUM_LANES];
    except_t               except_next;

    // A lane may write if it is live, targets a real register and did not overflow
    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            lane_writes[i] = results[i].valid && results[i].reg_wen &&
                             (results[i].reg_waddr != 5'd0) && !results[i].overflow;
        end
    end

    // The youngest writer of a register wins, older writes to it are dropped
    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            wb_next[i].wen   = lane_writes[i];
            wb_next[i].waddr = results[i].reg_waddr;
            wb_next[i].wdata = results[i].result;
            for (int j = i + 1; j < `NUM_LANES; j++) begin
                if (lane_writes[j] && (results[j].reg_waddr == results[i].reg_waddr)) begin
                    wb_next[i].wen = 1'b0;
                end
            end
        end
    end

    // Walk from youngest to oldest so the oldest overflowing lane sets epc
    always_comb begin
        except_next = '0;
        for (int i = `NUM_LANES - 1; i >= 0; i--) begin
            if (results[i].valid && results[i].overflow) begin
                except_next.valid = 1'b1;
                except_next.epc   = results[i].pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                wb[i].wen <= 1'b0;
            end
            except_out.valid <= 1'b0;
        end else begin
            wb         <= wb_next;
            except_out <= except_next;
        end
    end

endmodule

// ==== hw/dual_issue_exec.sv ====
`include "exec_defines.svh"

module dual_issue_exec
    import exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`NUM_LANES-1:0] ena,
    input  logic [`NUM_LANES-1:0] clear,
    input  issue_lane_t           issue_in [`NUM_LANES],
    output wb_port_t              wb       [`NUM_LANES],
    output except_t               except_out
);

    issue_lane_t  issue_q [`NUM_LANES];
    exec_result_t results [`NUM_LANES];

    id_ex_reg i_id_ex_reg (
        .clk      (clk),
        .reset    (reset),
        .ena      (ena),
        .clear    (clear),
        .issue_in (issue_in),
        .issue_q  (issue_q)
    );

    // One ALU per issue lane
    generate
        for (genvar g = 0; g < `NUM_LANES; g++) begin : g_alu
            alu_lane i_alu_lane (
                .lane   (issue_q[g]),
                .result (results[g])
            );
        end
    endgenerate

    retire_stage i_retire_stage (
        .clk        (clk),
        .reset      (reset),
        .results    (results),
        .wb         (wb),
        .except_out (except_out)
    );

endmodule

// ==== sim/tb_dual_issue_exec.sv ====
`include "exec_defines.svh"

module tb_dual_issue_exec
    import exec_pkg::*;
;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_CYCLES = 2000;
    localparam int TIMEOUT    = (NUM_CYCLES + 100) * CLK_PERIOD;

    logic                  clk;
    logic                  reset;
    logic [`NUM_LANES-1:0] ena;
    logic [`NUM_LANES-1:0] clear;
    issue_lane_t           issue_in [`NUM_LANES];
    wb_port_t              wb       [`NUM_LANES];
    except_t               except_out;

    // Reference state: what the issue register holds and what retire should show
    issue_lane_t m_issue [`NUM_LANES];
    wb_port_t    exp_wb  [`NUM_LANES];
    except_t     exp_exc;
    bit          addr_known;
    int          write_count;
    int          except_count;

    dual_issue_exec i_dut (
        .clk        (clk),
        .reset      (reset),
        .ena        (ena),
        .clear      (clear),
        .issue_in   (issue_in),
        .wb         (wb),
        .except_out (except_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped");
    endtask

    initial begin
        #(TIMEOUT);
        abort_run("Timeout: the random test did not complete in the expected time");
    end

    // Result and overflow of one lane, straight from the instruction set rules
    function automatic void lane_model(input issue_lane_t l, output logic [`XLEN-1:0] value,
                                       output logic ovf);
        logic [15:0]      imm;
        logic [4:0]       sh;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        longint           wide;
        longint           lim_hi;
        longint           lim_lo;
        imm    = l.inst.i.imm;
        sh     = l.inst.r.shamt;
        a      = l.rs_value;
        lim_hi = (longint'(1) <<< (`XLEN - 1)) - 1;
        lim_lo = -(longint'(1) <<< (`XLEN - 1));
        if (!l.alu_selb) begin
            b = l.rt_value;
        end else if (l.aluop inside {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR}) begin
            b = `XLEN'(imm);
        end else begin
            b = `XLEN'($signed(imm));
        end
        ovf = 1'b0;
        case (l.aluop)
            ALU_ADD, ALU_ADDU: begin
                value = a + b;
                wide  = longint'($signed(a)) + longint'($signed(b));
                ovf   = (l.aluop == ALU_ADD) && (wide > lim_hi || wide < lim_lo);
            end
            ALU_SUB, ALU_SUBU: begin
                value = a - b;
                wide  = longint'($signed(a)) - longint'($signed(b));
                ovf   = (l.aluop == ALU_SUB) && (wide > lim_hi || wide < lim_lo);
            end
            ALU_AND:  value = a & b;
            ALU_OR:   value = a | b;
            ALU_XOR:  value = a ^ b;
            ALU_NOR:  value = ~(a | b);
            ALU_SLT:  value = ($signed(a) < $signed(b)) ? `XLEN'(1) : '0;
            ALU_SLTU: value = (a < b) ? `XLEN'(1) : '0;
            ALU_SLL:  value = b << sh;
            ALU_SRL:  value = b >> sh;
            ALU_SRA:  value = $signed(b) >>> sh;
            ALU_LUI:  value = {imm, 16'h0000};
            default:  value = '0;
        endcase
    endfunction

    // Advance the reference by one rising edge using the inputs now applied
    task automatic model_edge();
        logic [`XLEN-1:0] value    [`NUM_LANES];
        logic             ovf      [`NUM_LANES];
        logic             writes   [`NUM_LANES];
        logic [31:0]      claimed;
        bit               exc_found;
        if (reset) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                exp_wb[i].wen = 1'b0;
                m_issue[i]    = '0;
            end
            exp_exc.valid = 1'b0;
            return;
        end
        for (int i = 0; i < `NUM_LANES; i++) begin
            lane_model(m_issue[i], value[i], ovf[i]);
            writes[i] = m_issue[i].valid && m_issue[i].reg_wen &&
                        (m_issue[i].reg_waddr != 5'd0) && !ovf[i];
        end
        // Youngest lane claims a register first, older writes to it are lost
        claimed = '0;
        for (int i = `NUM_LANES - 1; i >= 0; i--) begin
            exp_wb[i].wen   = writes[i] && !claimed[m_issue[i].reg_waddr];
            exp_wb[i].waddr = m_issue[i].reg_waddr;
            exp_wb[i].wdata = value[i];
            if (writes[i]) begin
                claimed[m_issue[i].reg_waddr] = 1'b1;
            end
            if (exp_wb[i].wen) begin
                write_count++;
            end
        end
        exc_found = 1'b0;
        exp_exc   = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (!exc_found && m_issue[i].valid && ovf[i]) begin
                exc_found     = 1'b1;
                exp_exc.valid = 1'b1;
                exp_exc.epc   = m_issue[i].pc;
                except_count++;
            end
        end
        addr_known = 1'b1;
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (clear[i]) begin
                m_issue[i] = '0;
            end else if (ena[i]) begin
                m_issue[i] = issue_in[i];
            end else begin
                m_issue[i].valid = 1'b0;
            end
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < `NUM_LANES; i++) begin
            assert (wb[i].wen === exp_wb[i].wen) else
                abort_run($sformatf("Mismatch wb[%0d].wen: expected %h, got %h",
                                    i, exp_wb[i].wen, wb[i].wen));
            if (addr_known) begin
                assert (wb[i].waddr === exp_wb[i].waddr) else
                    abort_run($sformatf("Mismatch wb[%0d].waddr: expected %h, got %h",
                                        i, exp_wb[i].waddr, wb[i].waddr));
            end
            if (exp_wb[i].wen) begin
                assert (wb[i].wdata === exp_wb[i].wdata) else
                    abort_run($sformatf("Mismatch wb[%0d].wdata: expected %h, got %h",
                                        i, exp_wb[i].wdata, wb[i].wdata));
            end
        end
        assert (except_out.valid === exp_exc.valid) else
            abort_run($sformatf("Mismatch except_out.valid: expected %h, got %h",
                                exp_exc.valid, except_out.valid));
        if (exp_exc.valid) begin
            assert (except_out.epc === exp_exc.epc) else
                abort_run($sformatf("Mismatch except_out.epc: expected %h, got %h",
                                    exp_exc.epc, except_out.epc));
        end
    endtask

    // Operands cluster around the signed limits to provoke overflow often
    function automatic logic [`XLEN-1:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h7fff_ffff;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0001;
            4:       return 32'h7fff_0000 + 32'($urandom_range(0, 32'hffff));
            default: return 32'($urandom);
        endcase
    endfunction

    task automatic drive_random_inputs();
        issue_lane_t l;
        for (int i = 0; i < `NUM_LANES; i++) begin
            l.valid     = ($urandom_range(0, 9) != 0);
            l.pc        = {28'($urandom), 4'h0};
            l.inst      = 32'($urandom);
            if ($urandom_range(0, 3) == 0) begin
                l.inst.i.imm = ($urandom_range(0, 1) != 0) ? 16'h7fff : 16'h8000;
            end
            l.rs_value  = pick_operand();
            l.rt_value  = pick_operand();
            l.aluop     = alu_op_e'(4'($urandom_range(0, 13)));
            l.alu_selb  = 1'($urandom_range(0, 1));
            l.reg_wen   = ($urandom_range(0, 6) != 0);
            l.reg_waddr = 5'($urandom_range(0, 3));
            issue_in[i] = l;
            ena[i]      = ($urandom_range(0, 4) != 0);
            clear[i]    = ($urandom_range(0, 9) == 0);
        end
    endtask

    task automatic run_cycle(input bit hold_reset, input bit random_inputs);
        @(negedge clk);
        check_outputs();
        reset = hold_reset;
        if (random_inputs) begin
            drive_random_inputs();
        end else begin
            ena   = '0;
            clear = '0;
        end
        model_edge();
    endtask

    initial begin
        void'($urandom(65));
        reset = 1'b1;
        ena   = '0;
        clear = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            issue_in[i] = '0;
            m_issue[i]  = '0;
            exp_wb[i]   = '0;
        end
        exp_exc      = '0;
        addr_known   = 1'b0;
        write_count  = 0;
        except_count = 0;
        // First edge sees reset high, the second reset edge follows in run_cycle
        model_edge();
        run_cycle(1'b1, 1'b0);
        for (int c = 0; c < NUM_CYCLES; c++) begin
            run_cycle(1'b0, 1'b1);
        end
        // Let the last accepted instructions drain out
        repeat (3) begin
            run_cycle(1'b0, 1'b0);
        end
        $display("Checked %0d writes and %0d exceptions", write_count, except_count);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/exec_pkg.sv
hw/id_ex_reg.sv
hw/alu_lane.sv
hw/retire_stage.sv
hw/dual_issue_exec.sv
sim/tb_dual_issue_exec.sv

// ==== run.sh ====
#!/bin/sh
# Builds the dual-issue execute testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_dual_issue_exec
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    -f list.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$("./$BUILD_DIR/V$TOP" 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The simulation only counts as passed when the testbench says so
if printf '%s\n' "$output" | grep -qxF '** PASS **'; then
    echo "Result: passed"
    exit 0
else
    echo "Result: failed"
    exit 1
fi
